//--- src/life_pkg.sv
// life engine package
// board geometry, row and tally types, and the row beat passed between stages

`default_nettype none

package life_pkg;

	////////////////////
	// board geometry
	////////////////////

	localparam int ROW_WIDTH     = 32;                  // cells per row
	localparam int BOARD_ROWS    = 16;                  // rows per board
	localparam int ROW_ADDR_BITS = $clog2(BOARD_ROWS);  // row index width, 4

	////////////////////
	// cell types
	////////////////////

	// one full board row, bit 0 is column 0
	typedef logic [ROW_WIDTH-1:0] row_t;

	// row index into a bank
	typedef logic [ROW_ADDR_BITS-1:0] row_addr_t;

	// vertical three cell count, 0..3
	typedef logic [1:0] tally3_t;

	// nine cell count incl. the centre, 0..9
	typedef logic [3:0] tally9_t;

	////////////////////
	// row stream
	////////////////////

	// one row on the pass stream, store -> stages -> write-back
	typedef struct packed {
		logic valid;  // beat carries a row
		logic first;  // first beat of a pass
		row_t cells;  // row payload
	} row_beat_t;

endpackage : life_pkg

`default_nettype wire

//--- src/life_row_store.sv
// life row store
// two row banks, host access to the front bank, pass reads and back bank write-back

`timescale 1ns/100ps
`default_nettype none

module life_row_store import life_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// host port, front bank
	input  logic      wr_en,
	input  row_addr_t wr_row,
	input  row_t      wr_data,
	input  logic      rd_en,
	input  row_addr_t rd_row,
	output logic      rd_valid,
	output row_t      rd_data,
	// pass read, front bank
	input  logic      pass_rd,
	input  row_addr_t pass_row,
	input  logic      pass_first,
	output row_beat_t pass_beat,
	// pass write-back, back bank
	input  logic      wb_en,
	input  row_addr_t wb_row,
	input  row_t      wb_data,
	input  logic      swap
);

	row_t bank0 [BOARD_ROWS];
	row_t bank1 [BOARD_ROWS];
	logic front;         // 0: bank0 is front

	logic      mem_we;   // merged write port
	logic      mem_sel;  // bank being written
	row_addr_t mem_addr;
	row_t      mem_data;

	logic rd_hit_q;      // host read, first stage
	row_t rd_q;
	logic pass_valid_q;
	logic pass_first_q;
	row_t pass_cells_q;

	////////////////////
	// write port
	////////////////////

	// host and write-back never overlap, host is held off while busy
	assign mem_we   = wr_en | wb_en;
	assign mem_sel  = wr_en ? front : ~front;  // host -> front, pass -> back
	assign mem_addr = wr_en ? wr_row : wb_row;
	assign mem_data = wr_en ? wr_data : wb_data;

	always_ff @(posedge clk) begin
		if (mem_we) begin
			if (mem_sel) bank1[mem_addr] <= mem_data;
			else         bank0[mem_addr] <= mem_data;
		end
	end

	// bank swap at end of pass, same edge as the last write-back
	always_ff @(posedge clk) begin
		if (rst)       front <= 1'b0;
		else if (swap) front <= ~front;
	end

	////////////////////
	// read ports
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_hit_q     <= 1'b0;
			rd_valid     <= 1'b0;
			pass_valid_q <= 1'b0;
			pass_first_q <= 1'b0;
		end else begin
			rd_hit_q     <= rd_en;
			rd_valid     <= rd_hit_q;            // 2 cycles after rd_en
			pass_valid_q <= pass_rd;
			pass_first_q <= pass_rd & pass_first;
		end
	end

	// payload regs, no reset
	always_ff @(posedge clk) begin
		if (rd_en)    rd_q         <= front ? bank1[rd_row] : bank0[rd_row];
		if (rd_hit_q) rd_data      <= rd_q;  // output register
		if (pass_rd)  pass_cells_q <= front ? bank1[pass_row] : bank0[pass_row];
	end

	assign pass_beat = '{valid: pass_valid_q, first: pass_first_q, cells: pass_cells_q};

endmodule : life_row_store

`default_nettype wire

//--- src/life_pass_sequencer.sv
// life pass sequencer
// accepts a step, streams the wrapped read addresses and counts the write-back rows

`timescale 1ns/100ps
`default_nettype none

module life_pass_sequencer import life_pkg::*; #(
	parameter int GENS = 2               // generation stages in the pipe
) (
	input  logic      clk,
	input  logic      rst,
	// host command
	input  logic      step,
	output logic      busy,
	// read stream to the store
	output logic      pass_rd,
	output row_addr_t pass_row,
	output logic      pass_first,
	// results from the last stage
	input  row_beat_t result,
	output logic      wb_en,
	output row_addr_t wb_row,
	output logic      swap
);

	// GENS halo rows above and below the board
	localparam int SPAN     = BOARD_ROWS + 2*GENS;
	localparam int CNT_BITS = $clog2(SPAN);

	logic                rd_active;  // read stream running
	logic [CNT_BITS-1:0] rd_cnt;     // reads issued this pass
	row_addr_t           wb_cnt;     // next write-back row
	logic                last_wb;

	////////////////////
	// command and reads
	////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			rd_active <= 1'b0;
			rd_cnt    <= '0;
		end else if (step && !busy) begin  // step only taken when idle
			busy      <= 1'b1;
			rd_active <= 1'b1;
			rd_cnt    <= '0;
		end else begin
			if (rd_active) begin
				if (rd_cnt == CNT_BITS'(SPAN-1))
					rd_active <= 1'b0;         // last halo row issued
				rd_cnt <= rd_cnt + 1'b1;
			end
			if (last_wb)
				busy <= 1'b0;                  // falls with the swap
		end
	end

	assign pass_rd    = rd_active;
	assign pass_first = rd_active && (rd_cnt == '0);

	// row = cnt - GENS mod BOARD_ROWS
	// BOARD_ROWS is a power of two so truncation does the wrap
	assign pass_row = row_addr_t'(rd_cnt - GENS);

	////////////////////
	// write-back
	////////////////////

	// counter restarts on the first result of a pass
	assign wb_en   = result.valid;
	assign wb_row  = result.first ? '0 : wb_cnt;
	assign last_wb = result.valid && (wb_row == row_addr_t'(BOARD_ROWS-1));
	assign swap    = last_wb;

	always_ff @(posedge clk) begin
		if (rst)
			wb_cnt <= '0;
		else if (result.valid)
			wb_cnt <= wb_row + 1'b1;   // wraps to 0 after the last row
	end

endmodule : life_pass_sequencer

`default_nettype wire

//--- src/life_gen_stage.sv
// life generation stage
// three row window, column tallies, wrapped horizontal sum and the life rule

`timescale 1ns/100ps
`default_nettype none

module life_gen_stage import life_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  row_beat_t in_beat,
	output row_beat_t out_beat
);

	row_t       prev1;      // row before the incoming one
	row_t       prev2;      // two rows back
	logic [1:0] seen;       // rows since first, saturates at 3
	logic       win_full;   // incoming beat completes a window
	logic       win_first;  // ... and it is the first window

	tally3_t [ROW_WIDTH-1:0] tally3;
	tally3_t [ROW_WIDTH-1:0] tally3_q;
	row_t                    mid_q;       // centre row of the window
	logic                    tally_valid;
	logic                    tally_first;

	tally9_t [ROW_WIDTH-1:0] tally9;
	row_t                    next_row;
	logic                    out_valid_q;
	logic                    out_first_q;
	row_t                    out_cells_q;

	////////////////////
	// row window
	////////////////////

	assign win_full  = in_beat.valid && !in_beat.first && (seen >= 2'd2);
	assign win_first = (seen == 2'd2);

	always_ff @(posedge clk) begin
		if (rst)
			seen <= 2'd0;
		else if (in_beat.valid) begin
			if (in_beat.first)      seen <= 2'd1;  // window restarts
			else if (seen != 2'd3)  seen <= seen + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_beat.valid) begin
			prev2 <= prev1;
			prev1 <= in_beat.cells;
		end
	end

	////////////////////
	// vertical tallies
	////////////////////

	always_comb begin
		for (int c = 0; c < ROW_WIDTH; c++)
			tally3[c] = {1'b0, in_beat.cells[c]} + {1'b0, prev1[c]} + {1'b0, prev2[c]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tally_valid <= 1'b0;
			tally_first <= 1'b0;
		end else begin
			tally_valid <= win_full;
			tally_first <= win_full & win_first;
		end
	end

	always_ff @(posedge clk) begin
		if (win_full) begin
			tally3_q <= tally3;
			mid_q    <= prev1;  // centre row of this window
		end
	end

	////////////////////
	// sum and rule
	////////////////////

	always_comb begin
		for (int c = 0; c < ROW_WIDTH; c++) begin
			tally9[c] = {2'b00, tally3_q[(c == 0) ? ROW_WIDTH-1 : c-1]}  // left, wraps
				+ {2'b00, tally3_q[c]}
				+ {2'b00, tally3_q[(c == ROW_WIDTH-1) ? 0 : c+1]};        // right, wraps
			// sum includes the centre: 3 -> born or kept, 4 -> kept if alive
			next_row[c] = (tally9[c] == 4'd3) || ((tally9[c] == 4'd4) && mid_q[c]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid_q <= 1'b0;
			out_first_q <= 1'b0;
		end else begin
			out_valid_q <= tally_valid;
			out_first_q <= tally_first;
		end
	end

	always_ff @(posedge clk) begin
		if (tally_valid) out_cells_q <= next_row;
	end

	assign out_beat = '{valid: out_valid_q, first: out_first_q, cells: out_cells_q};

endmodule : life_gen_stage

`default_nettype wire

//--- src/life_engine.sv
// toroidal life engine top
// row store, pass sequencer and a chain of GENS generation stages

`timescale 1ns/100ps
`default_nettype none

module life_engine import life_pkg::*; #(
	parameter int GENS = 2           // generations per step
) (
	input  logic      clk,
	input  logic      rst,
	// host row access
	input  logic      wr_en,
	input  row_addr_t wr_row,
	input  row_t      wr_data,
	input  logic      rd_en,
	input  row_addr_t rd_row,
	output logic      rd_valid,
	output row_t      rd_data,
	// step control
	input  logic      step,
	output logic      busy
);

	logic      pass_rd;
	row_addr_t pass_row;
	logic      pass_first;
	logic      wb_en;
	row_addr_t wb_row;
	logic      swap;

	// beat chain, [0] from the store, [GENS] back to write-back
	row_beat_t stage_beat [GENS+1];

	life_row_store u_store (
		.clk        (clk),
		.rst        (rst),
		.wr_en      (wr_en && !busy),  // host held off during a pass
		.wr_row     (wr_row),
		.wr_data    (wr_data),
		.rd_en      (rd_en && !busy),
		.rd_row     (rd_row),
		.rd_valid   (rd_valid),
		.rd_data    (rd_data),
		.pass_rd    (pass_rd),
		.pass_row   (pass_row),
		.pass_first (pass_first),
		.pass_beat  (stage_beat[0]),
		.wb_en      (wb_en),
		.wb_row     (wb_row),
		.wb_data    (stage_beat[GENS].cells),
		.swap       (swap)
	);

	life_pass_sequencer #(.GENS(GENS)) u_seq (
		.clk        (clk),
		.rst        (rst),
		.step       (step),
		.busy       (busy),
		.pass_rd    (pass_rd),
		.pass_row   (pass_row),
		.pass_first (pass_first),
		.result     (stage_beat[GENS]),
		.wb_en      (wb_en),
		.wb_row     (wb_row),
		.swap       (swap)
	);

	// one generation per stage, each trims one halo row top and bottom
	for (genvar g = 0; g < GENS; g++) begin : g_stage
		life_gen_stage u_stage (
			.clk      (clk),
			.rst      (rst),
			.in_beat  (stage_beat[g]),
			.out_beat (stage_beat[g+1])
		);
	end

endmodule : life_engine

`default_nettype wire

//--- testbench/life_tb_checks.svh
// life engine testbench checks
// typed compare tasks, host row access and whole-board load and readback

`ifndef LIFE_TB_CHECKS_SVH
`define LIFE_TB_CHECKS_SVH

// compare one board row
task automatic check_row(input string name, input row_t got, input row_t exp);
	if (got !== exp) begin
		$display("error at time %0t: %s = %h, expected %h", $time, name, got, exp);
		$display("TESTBENCH FAILED");
		$fatal(1, "row mismatch");
	end
endtask

// compare one status bit
task automatic check_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("error at time %0t: %s = %b, expected %b", $time, name, got, exp);
		$display("TESTBENCH FAILED");
		$fatal(1, "flag mismatch");
	end
endtask

// one host write that the front bank takes on the next edge
task automatic write_row(input row_addr_t r, input row_t d);
	@(posedge clk);
	wr_en   <= 1'b1;
	wr_row  <= r;
	wr_data <= d;
	@(posedge clk);
	wr_en <= 1'b0;
endtask

// one host read with the answer due exactly two cycles after rd_en
task automatic read_row(input row_addr_t r, output row_t d);
	@(posedge clk);
	rd_en  <= 1'b1;
	rd_row <= r;
	@(posedge clk);                          // rd_en sampled here
	rd_en <= 1'b0;
	@(negedge clk);
	check_flag("rd_valid", rd_valid, 1'b0);  // still low one cycle in
	@(negedge clk);
	check_flag("rd_valid", rd_valid, 1'b1);
	d = rd_data;
endtask

// whole board in a fresh random row order
task automatic load_board(input int idx);
	shuffle_order();
	for (int i = 0; i < BOARD_ROWS; i++)
		write_row(row_addr_t'(order[i]), init_board[idx][order[i]]);
endtask

// read every row back against the expected board
task automatic verify_board(input int idx);
	row_t got;
	for (int r = 0; r < BOARD_ROWS; r++) begin
		read_row(row_addr_t'(r), got);
		check_row($sformatf("rd_data row %0d", r), got, exp_board[idx][r]);
	end
endtask

`endif

//--- testbench/life_engine_tb.sv
// life engine testbench
// file driven board tests, host access checks and a watchdog on the whole run

`timescale 1ns/100ps
`default_nettype none

module life_engine_tb import life_pkg::*; ();

	localparam int GENS       = 2;                        // stages in the DUT
	localparam int MAX_TESTS  = 8;                        // records held from the file
	localparam int PASS_LIMIT = BOARD_ROWS + 2*GENS + 10; // cycles allowed per step

	typedef logic [8*24-1:0] token_t;  // one word from the test file

	logic      clk;
	logic      rst;
	logic      wr_en;
	row_addr_t wr_row;
	row_t      wr_data;
	logic      rd_en;
	row_addr_t rd_row;
	logic      rd_valid;
	row_t      rd_data;
	logic      step;
	logic      busy;

	token_t test_name  [MAX_TESTS];
	int     test_steps [MAX_TESTS];
	row_t   init_board [MAX_TESTS][BOARD_ROWS];
	row_t   exp_board  [MAX_TESTS][BOARD_ROWS];
	int     num_tests;

	row_t host_rows [BOARD_ROWS];  // random data for the access test
	int   order [BOARD_ROWS];      // shuffled row order
	int   watchdog_cycles;
	logic watchdog_armed;
	int   seed_dummy;

	life_engine #(.GENS(GENS)) u_dut (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_row   (wr_row),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.rd_row   (rd_row),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.step     (step),
		.busy     (busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	////////////////////
	// helpers
	////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run aborted");
	endtask

	// fisher-yates over 0..BOARD_ROWS-1
	task automatic shuffle_order();
		int j;
		int tmp;
		for (int i = 0; i < BOARD_ROWS; i++)
			order[i] = i;
		for (int i = BOARD_ROWS-1; i > 0; i--) begin
			j        = $urandom % (i+1);
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
	endtask

	// next word of the file with # lines skipped
	task automatic next_token(input int fd, output token_t tok, output logic ok);
		int                 code;
		logic               done;
		logic [8*200-1:0]   rest;
		ok   = 1'b0;
		done = 1'b0;
		tok  = '0;
		while (!done) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1)
				done = 1'b1;                 // end of file
			else if (tok == "#")
				code = $fgets(rest, fd);     // drop the rest of the comment
			else begin
				ok   = 1'b1;
				done = 1'b1;
			end
		end
	endtask

	// name, step count, initial board, expected board
	task automatic read_tests();
		int     fd;
		token_t tok;
		logic   ok;
		logic   more;
		row_t   value;
		int     steps;
		fd = $fopen("testbench/life_tests.txt", "r");
		if (fd == 0)
			abort_run("cannot open testbench/life_tests.txt");
		num_tests = 0;
		more      = 1'b1;
		while (more) begin
			next_token(fd, tok, ok);
			if (!ok)
				more = 1'b0;
			else begin
				if (num_tests == MAX_TESTS)
					abort_run("too many records in the test file");
				test_name[num_tests] = tok;
				next_token(fd, tok, ok);
				if (!ok || $sscanf(tok, "%d", steps) != 1)
					abort_run("bad step count in the test file");
				test_steps[num_tests] = steps;
				for (int r = 0; r < 2*BOARD_ROWS; r++) begin
					next_token(fd, tok, ok);
					if (!ok || $sscanf(tok, "%h", value) != 1)
						abort_run("bad or missing board row in the test file");
					if (r < BOARD_ROWS) init_board[num_tests][r] = value;
					else                exp_board[num_tests][r-BOARD_ROWS] = value;
				end
				num_tests++;
			end
		end
		$fclose(fd);
		if (num_tests == 0)
			abort_run("the test file holds no records");
	endtask

	`include "life_tb_checks.svh"

	// one step with stray host traffic and a second step while busy
	task automatic run_step();
		int        waited;
		row_addr_t stray_row;
		waited    = 0;
		stray_row = row_addr_t'($urandom);
		@(posedge clk);
		step <= 1'b1;
		@(posedge clk);
		step <= 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b1);  // rises on the accepting edge
		@(posedge clk);
		wr_en   <= 1'b1;
		wr_row  <= stray_row;
		wr_data <= $urandom;
		rd_en   <= 1'b1;
		rd_row  <= stray_row;
		step    <= 1'b1;
		@(posedge clk);
		wr_en <= 1'b0;
		rd_en <= 1'b0;
		step  <= 1'b0;
		@(negedge clk);
		while (busy) begin
			check_flag("rd_valid", rd_valid, 1'b0);  // read was dropped
			waited++;
			if (waited > PASS_LIMIT)
				abort_run($sformatf("busy did not fall within %0d cycles of a step",
					PASS_LIMIT));
			@(negedge clk);
		end
		// no late read answer and no second pass
		repeat (3) begin
			@(negedge clk);
			check_flag("rd_valid", rd_valid, 1'b0);
			check_flag("busy", busy, 1'b0);
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		row_t got;
		rst     <= 1'b1;
		wr_en   <= 1'b0;
		wr_row  <= '0;
		wr_data <= '0;
		rd_en   <= 1'b0;
		rd_row  <= '0;
		step    <= 1'b0;
		watchdog_armed = 1'b0;
		seed_dummy     = $urandom(32'he167);

		read_tests();
		watchdog_cycles = 100 + 8*BOARD_ROWS;  // reset and access test
		for (int t = 0; t < num_tests; t++)
			watchdog_cycles += test_steps[t]*PASS_LIMIT + 8*BOARD_ROWS;
		watchdog_armed = 1'b1;

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		// reset state
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("rd_valid", rd_valid, 1'b0);

		// host row access with random data and order
		for (int r = 0; r < BOARD_ROWS; r++)
			host_rows[r] = $urandom;
		shuffle_order();
		for (int i = 0; i < BOARD_ROWS; i++)
			write_row(row_addr_t'(order[i]), host_rows[order[i]]);
		shuffle_order();
		for (int i = 0; i < BOARD_ROWS; i++) begin
			read_row(row_addr_t'(order[i]), got);
			check_row($sformatf("rd_data row %0d", order[i]), got, host_rows[order[i]]);
		end

		// board records from the file
		for (int t = 0; t < num_tests; t++) begin
			$display("test %0s: %0d steps of %0d generations",
				test_name[t], test_steps[t], GENS);
			load_board(t);
			for (int s = 0; s < test_steps[t]; s++)
				run_step();
			verify_board(t);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

	// watchdog with its limit set once the records are known
	initial begin
		wait (watchdog_armed === 1'b1);
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", watchdog_cycles);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule : life_engine_tb

`default_nettype wire

//--- files.f
+incdir+testbench
src/life_pkg.sv
src/life_row_store.sv
src/life_pass_sequencer.sv
src/life_gen_stage.sv
src/life_engine.sv
testbench/life_engine_tb.sv

//--- Bender.yml
package:
  name: life_engine

sources:
  # design, package first
  - src/life_pkg.sv
  - src/life_row_store.sv
  - src/life_pass_sequencer.sv
  - src/life_gen_stage.sv
  - src/life_engine.sv

  # testbench
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/life_engine_tb.sv

//--- testbench/life_tests.txt
# record: <name> <steps>, then 16 initial rows, then 16 expected rows, one step is 2 generations
# rows are 32-bit hex, row 0 first, four rows per line, bit 0 is column 0

# blinkers across the column wrap, the row wrap and one in the open, period 2
blinker 3
00000400 00000400 00000000 00000000
00000000 80000003 00000000 00000000
00000000 00070000 00000000 00000000
00000000 00000000 00000000 00000400
# expected
00000400 00000400 00000000 00000000
00000000 80000003 00000000 00000000
00000000 00070000 00000000 00000000
00000000 00000000 00000000 00000400

# block on the corner wrap, a plain block and a beehive, all still
still_life 2
80000001 00000000 00000000 00000000
00000000 00000000 00000000 00003000
00003000 00000000 00600000 00900000
00600000 00000000 00000000 80000001
# expected
80000001 00000000 00000000 00000000
00000000 00000000 00000000 00003000
00003000 00000000 00600000 00900000
00600000 00000000 00000000 80000001

# single cells and a domino split by the column wrap, all die
lonely 1
00000000 00000000 00000000 00000020
00000000 00000000 00000000 00000000
80000001 00000000 00000000 00000000
00100000 00000000 00000000 00000000
# expected
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000

# glider near the corner, 8 generations move it one row and one column twice
glider_corner 4
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 40000000 80000000 e0000000
# expected
00000002 80000003 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000001

# glider inside the board, 16 generations carry it over both wrap edges
glider_cross 8
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 20000000 40000000
70000000 00000000 00000000 00000000
# expected
00000007 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 00000000 00000002 00000004
